//--- hw/uart_mon_pkg.sv
// ####################
// uart_mon package
// shared constants and types for the serial debug monitor
// ####################

`default_nettype none

package uart_mon_pkg;

	// clock cycles per UART bit, small for simulation
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int HALF_BIT = CLKS_PER_BIT / 2;

	// fifo depths
	localparam int RX_DEPTH = 4;
	localparam int TX_DEPTH = 8;

	// ascii codes used by parser and sender
	localparam logic [7:0] CHR_CR = 8'h0d;
	localparam logic [7:0] CHR_LF = 8'h0a;
	localparam logic [7:0] CHR_SP = 8'h20;
	localparam logic [7:0] CHR_W = "w";
	localparam logic [7:0] CHR_R = "r";
	localparam logic [7:0] CHR_G = "g";

	// one received byte, frame_err set when the stop bit was low
	typedef struct packed {
		logic       frame_err;
		logic [7:0] data;
	} rx_entry_t;

	typedef enum logic [1:0] {
		RESP_OK   = 2'd0,
		RESP_DATA = 2'd1,
		RESP_ERR  = 2'd2
	} resp_kind_e;

	typedef struct packed {
		resp_kind_e  kind;
		logic [31:0] data;
	} resp_req_t;

	typedef struct packed {
		logic        wr;
		logic [31:0] adr;
		logic [31:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire

//--- hw/uart_serial.sv
// ####################
// uart_serial
// bit-level UART receiver and transmitter
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_serial
	import uart_mon_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       i_rst_n,
	input  wire logic       i_rx,
	output logic            o_tx,
	output logic            o_rx_strobe,
	output rx_entry_t       o_rx_entry,
	input  wire logic       i_rx_full,
	output logic            o_rx_overrun,
	input  wire logic [7:0] i_tx_char,
	input  wire logic       i_tx_empty,
	output logic            o_tx_pop
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e             rx_state;
	logic [1:0]            rx_sync;
	logic [BAUD_CNT_W-1:0] rx_cnt;
	logic [2:0]            rx_bit;
	logic [7:0]            rx_shift;
	logic                  rx_done;

	logic                  tx_busy;
	logic [BAUD_CNT_W-1:0] tx_cnt;
	logic [3:0]            tx_bit;
	logic [9:0]            tx_shift;
	logic                  tx_tick;
	logic                  tx_last;

	// two flop synchronizer, idles high
	always_ff @(posedge clk) begin
		if (!i_rst_n)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], i_rx};
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			rx_cnt <= rx_cnt + 1'b1;
			case (rx_state)
			RX_IDLE: begin
				rx_cnt <= '0;
				if (!rx_sync[1])
					rx_state <= RX_START;
			end
			RX_START: begin
				// check the start bit at its middle
				if (rx_cnt == BAUD_CNT_W'(HALF_BIT - 1)) begin
					rx_cnt <= '0;
					rx_bit <= '0;
					rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
				end
			end
			RX_DATA: begin
				if (rx_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
					rx_cnt <= '0;
					rx_bit <= rx_bit + 1'b1;
					if (rx_bit == 3'd7)
						rx_state <= RX_STOP;
				end
			end
			default: begin
				if (rx_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
					rx_done <= 1'b1;
					rx_state <= RX_IDLE;
				end
			end
			endcase
		end
	end

	// lsb first, sampled mid-bit
	always_ff @(posedge clk) begin
		if (rx_state == RX_DATA && rx_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1))
			rx_shift <= {rx_sync[1], rx_shift[7:1]};
		if (rx_state == RX_STOP && rx_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1))
			o_rx_entry <= '{frame_err: ~rx_sync[1], data: rx_shift};
	end

	// a byte arriving at a full fifo is dropped
	assign o_rx_strobe = rx_done & ~i_rx_full;

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			o_rx_overrun <= 1'b0;
		else if (rx_done && i_rx_full)
			o_rx_overrun <= 1'b1;
	end

	assign tx_tick = tx_busy && tx_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1);
	assign tx_last = tx_tick && tx_bit == 4'd9;
	// next character may load in the last cycle of the stop bit
	assign o_tx_pop = (~tx_busy | tx_last) & ~i_tx_empty;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			tx_busy <= 1'b0;
			tx_cnt <= '0;
			tx_bit <= '0;
			tx_shift <= '1;
		end else if (o_tx_pop) begin
			tx_busy <= 1'b1;
			tx_cnt <= '0;
			tx_bit <= '0;
			tx_shift <= {1'b1, i_tx_char, 1'b0};
		end else if (tx_busy) begin
			tx_cnt <= tx_cnt + 1'b1;
			if (tx_tick) begin
				tx_cnt <= '0;
				tx_bit <= tx_bit + 1'b1;
				tx_shift <= {1'b1, tx_shift[9:1]};
				if (tx_last)
					tx_busy <= 1'b0;
			end
		end
	end

	assign o_tx = tx_shift[0];

endmodule

`default_nettype wire

//--- hw/uart_fifo.sv
// ####################
// uart_fifo
// first-word-fall-through fifo, payload type set by parameter
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
	parameter type T_ENTRY = logic [7:0],
	parameter int  DEPTH   = 4
) (
	input  wire logic   clk,
	input  wire logic   i_rst_n,
	input  wire logic   i_push,
	input  wire T_ENTRY i_wdata,
	input  wire logic   i_pop,
	output T_ENTRY      o_rdata,
	output logic        o_empty,
	output logic        o_full
);

	T_ENTRY                       mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]     wr_ptr;
	logic [$clog2(DEPTH)-1:0]     rd_ptr;
	logic [$clog2(DEPTH+1)-1:0]   count;
	logic                         do_push;
	logic                         do_pop;

	assign do_push = i_push & ~o_full;
	assign do_pop = i_pop & ~o_empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= i_wdata;
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// head of queue, valid while not empty
	assign o_rdata = mem[rd_ptr];
	assign o_empty = (count == '0);
	assign o_full = (count == $bits(count)'(DEPTH));

endmodule

`default_nettype wire

//--- hw/uart_cmd_parser.sv
// ####################
// uart_cmd_parser
// decodes w/r/g command lines, drives memory port and cpu start
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_cmd_parser
	import uart_mon_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        i_rst_n,
	input  wire rx_entry_t   i_rx_entry,
	input  wire logic        i_rx_empty,
	input  wire logic [31:0] i_mem_rdata,
	input  wire logic        i_mem_rvalid,
	input  wire logic        i_busy,
	output logic             o_rx_pop,
	output logic             o_mem_strobe,
	output mem_req_t         o_mem_req,
	output logic             o_cpu_start,
	output logic [31:0]      o_start_adr,
	output logic             o_resp_strobe,
	output resp_req_t        o_resp_req
);

	typedef enum logic [1:0] {S_IDLE, S_LINE, S_WAIT} state_e;

	state_e      state;
	logic [7:0]  letter;
	logic [1:0]  nfields;
	logic        in_field;
	logic        err;
	logic [31:0] field0;
	logic [31:0] field1;
	logic [7:0]  c;
	logic        is_term;
	logic        is_space;
	logic [4:0]  hex;
	logic        cmd_ok;

	// returns {valid, nibble}
	function automatic logic [4:0] hex_value(input logic [7:0] ch);
		logic [4:0] v;
		v = 5'h00;
		if (ch >= "0" && ch <= "9")
			v = {1'b1, 4'(ch - 8'h30)};
		else if (ch >= "a" && ch <= "f")
			v = {1'b1, 4'(ch - 8'h57)};
		else if (ch >= "A" && ch <= "F")
			v = {1'b1, 4'(ch - 8'h37)};
		return v;
	endfunction

	always_comb begin
		c = i_rx_entry.data;
		is_term = (c == CHR_CR) || (c == CHR_LF);
		is_space = (c == CHR_SP);
		hex = hex_value(c);
		cmd_ok = !err && (((letter == CHR_W) && nfields == 2'd2) ||
			((letter == CHR_R || letter == CHR_G) && nfields == 2'd1));
	end

	// hold input while a read is outstanding or a reply is going out
	assign o_rx_pop = ~i_rx_empty & ~i_busy & (state != S_WAIT);

	always_ff @(posedge clk) begin
		o_mem_strobe <= 1'b0;
		o_cpu_start <= 1'b0;
		o_resp_strobe <= 1'b0;
		if (!i_rst_n) begin
			state <= S_IDLE;
			nfields <= '0;
			in_field <= 1'b0;
			err <= 1'b0;
		end else if (state == S_WAIT) begin
			if (i_mem_rvalid) begin
				o_resp_strobe <= 1'b1;
				o_resp_req <= '{kind: RESP_DATA, data: i_mem_rdata};
				state <= S_IDLE;
			end
		end else if (o_rx_pop) begin
			if (is_term) begin
				nfields <= '0;
				in_field <= 1'b0;
				err <= 1'b0;
				state <= S_IDLE;
				// empty line gives no reply
				if (state == S_LINE) begin
					if (!cmd_ok) begin
						o_resp_strobe <= 1'b1;
						o_resp_req <= '{kind: RESP_ERR, data: 32'h0};
					end else if (letter == CHR_W) begin
						o_mem_strobe <= 1'b1;
						o_mem_req <= '{wr: 1'b1, adr: field0, wdata: field1};
						o_resp_strobe <= 1'b1;
						o_resp_req <= '{kind: RESP_OK, data: 32'h0};
					end else if (letter == CHR_R) begin
						o_mem_strobe <= 1'b1;
						o_mem_req <= '{wr: 1'b0, adr: field0, wdata: 32'h0};
						state <= S_WAIT;
					end else begin
						o_cpu_start <= 1'b1;
						o_start_adr <= field0;
						o_resp_strobe <= 1'b1;
						o_resp_req <= '{kind: RESP_OK, data: 32'h0};
					end
				end
			end else if (state == S_IDLE) begin
				// first non-space is the command letter
				if (!is_space || i_rx_entry.frame_err) begin
					letter <= c;
					err <= i_rx_entry.frame_err;
					state <= S_LINE;
				end
			end else if (i_rx_entry.frame_err || (!is_space && !hex[4])) begin
				err <= 1'b1;
			end else if (is_space) begin
				in_field <= 1'b0;
			end else if (!in_field) begin
				in_field <= 1'b1;
				if (nfields != 2'd3)
					nfields <= nfields + 1'b1;
				if (nfields == 2'd0)
					field0 <= {28'h0, hex[3:0]};
				else if (nfields == 2'd1)
					field1 <= {28'h0, hex[3:0]};
			end else if (nfields == 2'd1) begin
				// long fields keep their last eight digits
				field0 <= {field0[27:0], hex[3:0]};
			end else if (nfields == 2'd2) begin
				field1 <= {field1[27:0], hex[3:0]};
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/uart_resp_sender.sv
// ####################
// uart_resp_sender
// turns a response request into ascii for the tx fifo
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_resp_sender
	import uart_mon_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      i_rst_n,
	input  wire logic      i_resp_strobe,
	input  wire resp_req_t i_resp_req,
	input  wire logic      i_tx_full,
	output logic           o_busy,
	output logic           o_tx_push,
	output logic [7:0]     o_tx_char
);

	resp_kind_e  kind;
	logic [31:0] data_sr;
	logic [3:0]  idx;
	logic        last;

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		logic [7:0] ch;
		if (n < 4'd10)
			ch = 8'h30 + {4'h0, n};
		else
			ch = 8'h37 + {4'h0, n};
		return ch;
	endfunction

	// character for the current index
	always_comb begin
		o_tx_char = CHR_LF;
		last = 1'b0;
		case (kind)
		RESP_OK: begin
			case (idx)
			4'd0: o_tx_char = "O";
			4'd1: o_tx_char = "K";
			4'd2: o_tx_char = CHR_CR;
			default: last = 1'b1;
			endcase
		end
		RESP_DATA: begin
			if (idx < 4'd8)
				o_tx_char = hex_char(data_sr[31:28]);
			else if (idx == 4'd8)
				o_tx_char = CHR_CR;
			else
				last = 1'b1;
		end
		default: begin
			case (idx)
			4'd0: o_tx_char = "?";
			4'd1: o_tx_char = CHR_CR;
			default: last = 1'b1;
			endcase
		end
		endcase
	end

	// full tx fifo stalls the sequence
	assign o_tx_push = o_busy & ~i_tx_full;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_busy <= 1'b0;
			idx <= '0;
		end else if (!o_busy && i_resp_strobe) begin
			o_busy <= 1'b1;
			idx <= '0;
		end else if (o_tx_push) begin
			if (last)
				o_busy <= 1'b0;
			else
				idx <= idx + 1'b1;
		end
	end

	// nibbles go out msb first
	always_ff @(posedge clk) begin
		if (!o_busy && i_resp_strobe) begin
			kind <= i_resp_req.kind;
			data_sr <= i_resp_req.data;
		end else if (o_tx_push) begin
			data_sr <= {data_sr[27:0], 4'h0};
		end
	end

endmodule

`default_nettype wire

//--- hw/uart_mon_top.sv
// ####################
// uart_mon_top
// serial debug monitor, uart line to memory port and cpu start
// ####################

`timescale 1ns/1ps
`default_nettype none

module uart_mon_top
	import uart_mon_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        i_rst_n,
	input  wire logic        i_rx,
	output logic             o_tx,
	output logic             o_mem_strobe,
	output mem_req_t         o_mem_req,
	input  wire logic [31:0] i_mem_rdata,
	input  wire logic        i_mem_rvalid,
	output logic             o_cpu_start,
	output logic [31:0]      o_start_adr,
	output logic             o_rx_overrun
);

	// inbound chain
	logic      rx_strobe;
	rx_entry_t rx_entry;
	rx_entry_t rx_head;
	logic      rx_pop;
	logic      rx_empty;
	logic      rx_full;

	// outbound chain
	logic       resp_strobe;
	resp_req_t  resp_req;
	logic       busy;
	logic       tx_push;
	logic [7:0] tx_char;
	logic [7:0] tx_head;
	logic       tx_pop;
	logic       tx_empty;
	logic       tx_full;

	uart_serial u_serial (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_rx(i_rx),
		.o_tx(o_tx),
		.o_rx_strobe(rx_strobe),
		.o_rx_entry(rx_entry),
		.i_rx_full(rx_full),
		.o_rx_overrun(o_rx_overrun),
		.i_tx_char(tx_head),
		.i_tx_empty(tx_empty),
		.o_tx_pop(tx_pop)
	);

	uart_fifo #(.T_ENTRY(rx_entry_t), .DEPTH(RX_DEPTH)) u_rx_fifo (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_push(rx_strobe),
		.i_wdata(rx_entry),
		.i_pop(rx_pop),
		.o_rdata(rx_head),
		.o_empty(rx_empty),
		.o_full(rx_full)
	);

	uart_cmd_parser u_parser (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_rx_entry(rx_head),
		.i_rx_empty(rx_empty),
		.i_mem_rdata(i_mem_rdata),
		.i_mem_rvalid(i_mem_rvalid),
		.i_busy(busy),
		.o_rx_pop(rx_pop),
		.o_mem_strobe(o_mem_strobe),
		.o_mem_req(o_mem_req),
		.o_cpu_start(o_cpu_start),
		.o_start_adr(o_start_adr),
		.o_resp_strobe(resp_strobe),
		.o_resp_req(resp_req)
	);

	uart_resp_sender u_sender (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_resp_strobe(resp_strobe),
		.i_resp_req(resp_req),
		.i_tx_full(tx_full),
		.o_busy(busy),
		.o_tx_push(tx_push),
		.o_tx_char(tx_char)
	);

	uart_fifo #(.T_ENTRY(logic [7:0]), .DEPTH(TX_DEPTH)) u_tx_fifo (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_push(tx_push),
		.i_wdata(tx_char),
		.i_pop(tx_pop),
		.o_rdata(tx_head),
		.o_empty(tx_empty),
		.o_full(tx_full)
	);

endmodule

`default_nettype wire

//--- verification/tb_uart_mon.sv
// ####################
// tb_uart_mon
// directed testbench with a uart host model and a memory model
// ####################

`timescale 1ns/1ps
`default_nettype none

module tb_uart_mon
	import uart_mon_pkg::*;
();

	// 20 characters of 10 bits per line and as much again for the reply
	localparam int LINE_CYCLES = 20 * 10 * CLKS_PER_BIT * 2;
	// 1 write, 4 reads, 1 go, 5 error and format lines, 1 read line and 1 line of spaces
	localparam int NUM_LINES = 13;
	localparam int MAX_CYCLES = NUM_LINES * LINE_CYCLES;

	logic        clk;
	logic        i_rst_n;
	logic        i_rx;
	logic        o_tx;
	logic        o_mem_strobe;
	mem_req_t    o_mem_req;
	logic [31:0] i_mem_rdata;
	logic        i_mem_rvalid;
	logic        o_cpu_start;
	logic [31:0] o_start_adr;
	logic        o_rx_overrun;

	logic [31:0] mem_model [logic [31:0]];
	integer      seed;
	int          lat;
	logic [31:0] rd_adr;
	logic        hold_rvalid;
	int          wr_count;
	int          rd_count;
	int          start_count;
	int          cycle_count;
	int          bit_idx;
	logic [7:0]  rx_ch;
	logic [7:0]  tx_q [$];

	uart_mon_top u_dut (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_rx(i_rx),
		.o_tx(o_tx),
		.o_mem_strobe(o_mem_strobe),
		.o_mem_req(o_mem_req),
		.i_mem_rdata(i_mem_rdata),
		.i_mem_rvalid(i_mem_rvalid),
		.o_cpu_start(o_cpu_start),
		.o_start_adr(o_start_adr),
		.o_rx_overrun(o_rx_overrun)
	);

	always #20 clk = ~clk;

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAILED time=%0t %s: got %h, expected %h", $time, name, got, exp);
		stop_run();
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("run did not finish within %0d cycles", MAX_CYCLES);
			stop_run();
		end
	end

	// memory model answers reads after 1 to 6 cycles
	always begin
		@(negedge clk);
		if (i_rst_n && o_mem_strobe) begin
			if (o_mem_req.wr) begin
				mem_model[o_mem_req.adr] = o_mem_req.wdata;
				wr_count++;
			end else begin
				rd_count++;
				rd_adr = o_mem_req.adr;
				lat = 1 + int'($unsigned($random(seed)) % 6);
				repeat (lat) @(posedge clk);
				while (hold_rvalid)
					@(posedge clk);
				i_mem_rdata <= mem_model.exists(rd_adr) ? mem_model[rd_adr] : 32'h0;
				i_mem_rvalid <= 1'b1;
				@(posedge clk);
				i_mem_rvalid <= 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (i_rst_n && o_cpu_start)
			start_count++;
	end

	// host receiver samples mid-bit on the falling edge
	always begin
		@(negedge clk);
		if (i_rst_n && o_tx === 1'b0) begin
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				rx_ch[bit_idx] = o_tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			assert (o_tx === 1'b1) else report_value("o_tx stop bit", {31'h0, o_tx}, 32'h1);
			tx_q.push_back(rx_ch);
		end
	end

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		int k;
		frame = {1'b1, b, 1'b0};
		for (k = 0; k < 10; k++) begin
			@(posedge clk);
			i_rx <= frame[k];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic send_line(input string s);
		int k;
		for (k = 0; k < s.len(); k++)
			send_byte(8'(s.getc(k)));
		send_byte(CHR_CR);
	endtask

	task automatic expect_char(input logic [7:0] exp);
		logic [7:0] ch;
		while (tx_q.size() == 0)
			@(negedge clk);
		ch = tx_q.pop_front();
		assert (ch == exp) else report_value("o_tx character", {24'h0, ch}, {24'h0, exp});
	endtask

	task automatic expect_reply(input string body);
		int k;
		for (k = 0; k < body.len(); k++)
			expect_char(8'(body.getc(k)));
		expect_char(CHR_CR);
		expect_char(CHR_LF);
	endtask

	// eight upper-case hex digits
	function automatic string hex_word(input logic [31:0] w);
		string s;
		s = $sformatf("%08h", w);
		return s.toupper();
	endfunction

	function automatic logic [31:0] model_word(input logic [31:0] adr);
		return mem_model.exists(adr) ? mem_model[adr] : 32'h0;
	endfunction

	task automatic test_write();
		int wr_before;
		wr_before = wr_count;
		send_line("w 00000010 DEADBEEF");
		expect_reply("OK");
		assert (wr_count == wr_before + 1) else report_value("write strobes", wr_count, wr_before + 1);
		assert (model_word(32'h10) == 32'hdeadbeef)
			else report_value("memory word 00000010", model_word(32'h10), 32'hdeadbeef);
	endtask

	task automatic test_read();
		logic [31:0] rnd_adr;
		logic [31:0] rnd_word;
		send_line("r 00000010");
		expect_reply("DEADBEEF");
		repeat (3) begin
			rnd_adr = $random(seed);
			rnd_word = $random(seed);
			mem_model[rnd_adr] = rnd_word;
			send_line($sformatf("r %08x", rnd_adr));
			expect_reply(hex_word(rnd_word));
		end
	endtask

	task automatic test_go();
		int start_before;
		start_before = start_count;
		send_line("g 00000400");
		expect_reply("OK");
		assert (start_count == start_before + 1)
			else report_value("o_cpu_start pulses", start_count, start_before + 1);
		assert (o_start_adr == 32'h400) else report_value("o_start_adr", o_start_adr, 32'h400);
	endtask

	task automatic test_errors();
		int mem_before;
		int start_before;
		mem_before = wr_count + rd_count;
		start_before = start_count;
		send_line("x 00000010");
		expect_reply("?");
		send_line("r 0000001z");
		expect_reply("?");
		send_line("w 00000010");
		expect_reply("?");
		assert (wr_count + rd_count == mem_before)
			else report_value("o_mem_strobe count", wr_count + rd_count, mem_before);
		assert (start_count == start_before)
			else report_value("o_cpu_start pulses", start_count, start_before);
		// extra spaces and lower-case digits
		send_line("  w  000000a0   cafef00d ");
		expect_reply("OK");
		assert (model_word(32'ha0) == 32'hcafef00d)
			else report_value("memory word 000000a0", model_word(32'ha0), 32'hcafef00d);
		send_line("r A0");
		expect_reply("CAFEF00D");
	endtask

	task automatic test_overrun();
		int rd_before;
		int k;
		rd_before = rd_count;
		hold_rvalid = 1'b1;
		send_line("r 00000010");
		while (rd_count == rd_before)
			@(negedge clk);
		assert (o_rx_overrun == 1'b0) else report_value("o_rx_overrun", {31'h0, o_rx_overrun}, 32'h0);
		// the stalled parser lets the fifo fill and the last two spaces drop
		for (k = 0; k < RX_DEPTH + 2; k++)
			send_byte(CHR_SP);
		repeat (CLKS_PER_BIT) @(negedge clk);
		assert (o_rx_overrun == 1'b1) else report_value("o_rx_overrun", {31'h0, o_rx_overrun}, 32'h1);
		hold_rvalid = 1'b0;
		expect_reply("DEADBEEF");
	endtask

	initial begin
		seed = 32'h44f2;
		clk = 1'b0;
		i_rst_n <= 1'b0;
		i_rx <= 1'b1;
		i_mem_rdata <= 32'h0;
		i_mem_rvalid <= 1'b0;
		hold_rvalid = 1'b0;
		wr_count = 0;
		rd_count = 0;
		start_count = 0;
		cycle_count <= 0;
		repeat (4) @(posedge clk);
		i_rst_n <= 1'b1;
		repeat (4) @(posedge clk);
		test_write();
		test_read();
		test_go();
		test_errors();
		test_overrun();
		// two character times with no further output expected
		repeat (20 * CLKS_PER_BIT) @(negedge clk);
		assert (tx_q.size() == 0) else begin
			$display("unexpected characters on o_tx after the last reply");
			stop_run();
		end
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- uart_mon.f
hw/uart_mon_pkg.sv
hw/uart_serial.sv
hw/uart_fifo.sv
hw/uart_cmd_parser.sv
hw/uart_resp_sender.sv
hw/uart_mon_top.sv
verification/tb_uart_mon.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_mon
FILELIST  ?= uart_mon.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
